// ==== eim_bus_pkg.sv ====
package eim_bus_pkg;

   // ####################################################################
   // Bus geometry
   // ####################################################################

   localparam int DATA_W = 16;               // Multiplexed address/data lines
   localparam int ADDR_W = 19;               // Full bus address
   localparam int A_HI_W = ADDR_W - DATA_W;  // Separate upper address lines

   localparam int BURST_BEATS = 4;           // Data beats per register
   localparam int BEAT_CNT_W  = 3;           // Counts 0..BURST_BEATS

   // ####################################################################
   // Bus beat and readback
   // ####################################################################

   // One clock cycle of the bus as seen after the capture flops
   typedef struct packed {
      logic [DATA_W-1:0] ad;     // Lower address on adv beats, data otherwise
      logic [A_HI_W-1:0] a;      // Upper address
      logic              adv;    // Address valid
      logic              rw;     // High for read
      logic              cs;     // Chip select
   } bus_beat_t;

   // A readback source, or the registered pair on the data pins
   typedef struct packed {
      logic              oe;
      logic [DATA_W-1:0] data;
   } readback_t;

endpackage

// ==== reg_map_pkg.sv ====
package reg_map_pkg;

   // ####################################################################
   // Register payloads
   // ####################################################################

   // Control layout, also used by the threshold register
   typedef struct packed {
      logic        enable;
      logic [3:0]  mode;
      logic [26:0] divider;
      logic [31:0] limit;       // Words 0 and 1 of the burst
   } ctrl_word_t;

   // Four data lanes, lane0 is the first beat of a burst
   typedef struct packed {
      logic [eim_bus_pkg::DATA_W-1:0] lane3;
      logic [eim_bus_pkg::DATA_W-1:0] lane2;
      logic [eim_bus_pkg::DATA_W-1:0] lane1;
      logic [eim_bus_pkg::DATA_W-1:0] lane0;
   } pattern_word_t;

   // ####################################################################
   // Register map
   // ####################################################################

   // Word offsets from the bank base address
   localparam logic [eim_bus_pkg::ADDR_W-1:0] OFF_CTRL    = 'd0;
   localparam logic [eim_bus_pkg::ADDR_W-1:0] OFF_THRESH  = 'd1;
   localparam logic [eim_bus_pkg::ADDR_W-1:0] OFF_PATTERN = 'd2;

   localparam int NUM_REGS = 3;

endpackage

// ==== bus_capture.sv ====
`timescale 1ns/1ps

module bus_capture (
   input  logic                                clk,
   input  logic                                reset,
   input  logic [eim_bus_pkg::DATA_W-1:0]      bus_ad,
   input  logic [eim_bus_pkg::A_HI_W-1:0]      bus_a,
   input  logic                                adv,
   input  logic                                rw,
   input  logic                                cs,
   output eim_bus_pkg::bus_beat_t              beat
);

   // Single capture point for the whole bank; registers work off beat only
   always_ff @(posedge clk) begin
      beat.ad  <= bus_ad;
      beat.a   <= bus_a;
      beat.rw  <= rw;
      beat.adv <= adv;
      beat.cs  <= cs;

      // Keep cs and adv low so no register sees a burst start out of reset
      if (reset) begin
         beat.cs  <= 1'b0;
         beat.adv <= 1'b0;
      end
   end

endmodule

// ==== burst_reg.sv ====
`timescale 1ns/1ps

module burst_reg #(
   parameter logic [eim_bus_pkg::ADDR_W-1:0] MY_ADDR = '0,
   parameter type payload_t = logic [63:0]
) (
   input  logic                      clk,
   input  logic                      reset,
   input  eim_bus_pkg::bus_beat_t    beat,
   output payload_t                  q,
   output eim_bus_pkg::readback_t    rbk_src,
   output logic                      strobe
);

   localparam int PAYLOAD_W = $bits(payload_t);
   localparam int SEL_W     = $clog2(eim_bus_pkg::BURST_BEATS);

   // ####################################################################
   // Beat decode
   // ####################################################################

   logic                                  active;     // Burst to this register
   logic                                  wrote;      // Burst wrote a word
   logic [eim_bus_pkg::BEAT_CNT_W-1:0]    beat_cnt;   // Next word of the burst
   logic [SEL_W-1:0]                      word_sel;
   logic [PAYLOAD_W-1:0]                  store;

   logic addr_beat;
   logic data_beat;
   logic addr_hit;
   logic in_range;
   logic end_burst;

   assign addr_beat = beat.cs && beat.adv;
   assign data_beat = beat.cs && !beat.adv;
   assign addr_hit  = addr_beat && ({beat.a, beat.ad} == MY_ADDR);

   // Data beat that still lands in one of the four words
   assign in_range  = active && data_beat && (beat_cnt < eim_bus_pkg::BURST_BEATS);

   // cs low, or an address beat for somebody else
   assign end_burst = active && (!beat.cs || (addr_beat && !addr_hit));

   assign word_sel  = beat_cnt[SEL_W-1:0];

   // ####################################################################
   // Burst control
   // ####################################################################

   always_ff @(posedge clk) begin
      if (reset) begin
         active   <= 1'b0;
         wrote    <= 1'b0;
         beat_cnt <= '0;
         strobe   <= 1'b0;
      end else begin
         // Pulses once as active drops after a write burst
         strobe <= end_burst && wrote;

         if (addr_hit) begin
            active   <= 1'b1;
            wrote    <= 1'b0;
            beat_cnt <= '0;
         end else if (end_burst) begin
            active   <= 1'b0;
            wrote    <= 1'b0;
            beat_cnt <= '0;
         end else if (in_range) begin
            beat_cnt <= beat_cnt + 1'b1;    // Stops at BURST_BEATS
            if (!beat.rw) begin
               wrote <= 1'b1;
            end
         end
      end
   end

   // ####################################################################
   // Storage and readback
   // ####################################################################

   // Word 0 is the low 16 bits of the payload
   always_ff @(posedge clk) begin
      if (in_range && !beat.rw) begin
         store[word_sel*eim_bus_pkg::DATA_W +: eim_bus_pkg::DATA_W] <= beat.ad;
      end
   end

   assign q = payload_t'(store);

   // Word for the current read beat, registered downstream in the mux
   always_comb begin
      rbk_src.oe   = in_range && beat.rw;
      rbk_src.data = store[word_sel*eim_bus_pkg::DATA_W +: eim_bus_pkg::DATA_W];
   end

endmodule

// ==== readback_mux.sv ====
`timescale 1ns/1ps

module readback_mux #(
   parameter int NUM_SRC = 3
) (
   input  logic                      clk,
   input  logic                      reset,
   input  eim_bus_pkg::readback_t    src [NUM_SRC],
   output eim_bus_pkg::readback_t    rbk
);

   eim_bus_pkg::readback_t pick;

   // Lowest index wins; address decode keeps at most one source active
   always_comb begin
      pick = '0;
      for (int i = NUM_SRC - 1; i >= 0; i--) begin
         if (src[i].oe) begin
            pick = src[i];
         end
      end
   end

   // Output pair toward the data pins
   always_ff @(posedge clk) begin
      rbk <= pick;
      if (reset) begin
         rbk.oe <= 1'b0;
      end
   end

endmodule

// ==== eim_reg_bank.sv ====
`timescale 1ns/1ps

module eim_reg_bank #(
   parameter logic [eim_bus_pkg::ADDR_W-1:0] BASE_ADDR = '0
) (
   input  logic                                clk,
   input  logic                                reset,
   input  logic [eim_bus_pkg::DATA_W-1:0]      bus_ad,
   input  logic [eim_bus_pkg::A_HI_W-1:0]      bus_a,
   input  logic                                adv,
   input  logic                                rw,
   input  logic                                cs,
   output reg_map_pkg::ctrl_word_t             ctrl_q,
   output reg_map_pkg::ctrl_word_t             thresh_q,
   output reg_map_pkg::pattern_word_t          pattern_q,
   output logic                                ctrl_stb,
   output logic                                thresh_stb,
   output logic                                pattern_stb,
   output eim_bus_pkg::readback_t              rbk
);

   eim_bus_pkg::bus_beat_t   beat;
   eim_bus_pkg::readback_t   rbk_src [reg_map_pkg::NUM_REGS];

   // ####################################################################
   // Bus capture
   // ####################################################################

   bus_capture i_capture (
      .clk    (clk),
      .reset  (reset),
      .bus_ad (bus_ad),
      .bus_a  (bus_a),
      .adv    (adv),
      .rw     (rw),
      .cs     (cs),
      .beat   (beat)
   );

   // ####################################################################
   // Registers
   // ####################################################################

   burst_reg #(
      .MY_ADDR   (BASE_ADDR + reg_map_pkg::OFF_CTRL),
      .payload_t (reg_map_pkg::ctrl_word_t)
   ) i_ctrl (
      .clk     (clk),
      .reset   (reset),
      .beat    (beat),
      .q       (ctrl_q),
      .rbk_src (rbk_src[0]),
      .strobe  (ctrl_stb)
   );

   // Same layout as control
   burst_reg #(
      .MY_ADDR   (BASE_ADDR + reg_map_pkg::OFF_THRESH),
      .payload_t (reg_map_pkg::ctrl_word_t)
   ) i_thresh (
      .clk     (clk),
      .reset   (reset),
      .beat    (beat),
      .q       (thresh_q),
      .rbk_src (rbk_src[1]),
      .strobe  (thresh_stb)
   );

   burst_reg #(
      .MY_ADDR   (BASE_ADDR + reg_map_pkg::OFF_PATTERN),
      .payload_t (reg_map_pkg::pattern_word_t)
   ) i_pattern (
      .clk     (clk),
      .reset   (reset),
      .beat    (beat),
      .q       (pattern_q),
      .rbk_src (rbk_src[2]),
      .strobe  (pattern_stb)
   );

   // Readback path
   readback_mux #(
      .NUM_SRC (reg_map_pkg::NUM_REGS)
   ) i_rbk_mux (
      .clk   (clk),
      .reset (reset),
      .src   (rbk_src),
      .rbk   (rbk)
   );

endmodule

// ==== tb_eim_reg_bank.sv ====
`timescale 1ns/1ps

module tb_eim_reg_bank;

   localparam logic [eim_bus_pkg::ADDR_W-1:0] BASE = 19'h4_1000;
   localparam int TIMEOUT = 20;      // Cycles allowed for a burst to complete
   localparam int NUM_RAND = 60;

   logic                              clk;
   logic                              reset;
   logic [eim_bus_pkg::DATA_W-1:0]    bus_ad;
   logic [eim_bus_pkg::A_HI_W-1:0]    bus_a;
   logic                              adv;
   logic                              rw;
   logic                              cs;
   reg_map_pkg::ctrl_word_t           ctrl_q;
   reg_map_pkg::ctrl_word_t           thresh_q;
   reg_map_pkg::pattern_word_t        pattern_q;
   logic                              ctrl_stb;
   logic                              thresh_stb;
   logic                              pattern_stb;
   eim_bus_pkg::readback_t            rbk;

   logic [63:0]  shadow [reg_map_pkg::NUM_REGS];    // Reference copy of each register
   logic [15:0]  got_q [$];                         // Readback words of the current burst
   int           stb_cnt [reg_map_pkg::NUM_REGS];
   int           oe_cnt;
   int           value_errs;
   int           timeout_errs;
   logic [31:0]  rng;

   eim_reg_bank #(
      .BASE_ADDR (BASE)
   ) i_dut (
      .clk         (clk),
      .reset       (reset),
      .bus_ad      (bus_ad),
      .bus_a       (bus_a),
      .adv         (adv),
      .rw          (rw),
      .cs          (cs),
      .ctrl_q      (ctrl_q),
      .thresh_q    (thresh_q),
      .pattern_q   (pattern_q),
      .ctrl_stb    (ctrl_stb),
      .thresh_stb  (thresh_stb),
      .pattern_stb (pattern_stb),
      .rbk         (rbk)
   );

   always #2 clk = ~clk;

   // Output monitor, sampled mid-cycle
   always @(negedge clk) begin
      if (!reset) begin
         if (rbk.oe) begin
            got_q.push_back(rbk.data);
            oe_cnt++;
         end
         if (ctrl_stb)
            stb_cnt[0]++;
         if (thresh_stb)
            stb_cnt[1]++;
         if (pattern_stb)
            stb_cnt[2]++;
      end
   end

   // ####################################################################
   // Reference model
   // ####################################################################

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   function automatic int reg_index(input logic [eim_bus_pkg::ADDR_W-1:0] addr);
      if (addr == BASE + reg_map_pkg::OFF_CTRL)
         return 0;
      if (addr == BASE + reg_map_pkg::OFF_THRESH)
         return 1;
      if (addr == BASE + reg_map_pkg::OFF_PATTERN)
         return 2;
      return -1;                                    // Outside the bank
   endfunction

   // Applies one burst to the shadow and returns the payload expected afterwards
   function automatic logic [63:0] model_burst(input int idx, input logic is_read,
                                               input int nbeats, input logic [95:0] data);
      int k;
      if (idx < 0)
         return 64'h0;
      if (!is_read) begin
         for (k = 0; k < nbeats && k < 4; k++)
            shadow[idx][k*16 +: 16] = data[k*16 +: 16];
      end
      return shadow[idx];
   endfunction

   function automatic logic [15:0] model_word(input int idx, input int k);
      return shadow[idx][k*16 +: 16];
   endfunction

   // ####################################################################
   // Compare tasks
   // ####################################################################

   task automatic check_ctrl(input string name, input reg_map_pkg::ctrl_word_t exp,
                             input reg_map_pkg::ctrl_word_t act);
      if (act !== exp) begin
         $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
         value_errs++;
      end
   endtask

   task automatic check_pattern(input string name, input reg_map_pkg::pattern_word_t exp,
                                input reg_map_pkg::pattern_word_t act);
      if (act !== exp) begin
         $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
         value_errs++;
      end
   endtask

   task automatic check_word(input string name, input logic [15:0] exp, input logic [15:0] act);
      if (act !== exp) begin
         $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
         value_errs++;
      end
   endtask

   task automatic check_strobe(input string name, input int exp, input int act);
      if (act != exp) begin
         $display("CHECK FAILED %s: expected %0d pulses, actual %0d", name, exp, act);
         value_errs++;
      end
   endtask

   task automatic verify_oe_cycles(input string name, input int exp, input int act);
      if (act != exp) begin
         $display("CHECK FAILED %s oe: expected %0d cycles, actual %0d", name, exp, act);
         value_errs++;
      end
   endtask

   task automatic check_payloads(input string name, input int idx, input logic [63:0] exp);
      reg_map_pkg::ctrl_word_t    exp_ctrl;
      reg_map_pkg::ctrl_word_t    exp_thresh;
      reg_map_pkg::pattern_word_t exp_pattern;
      exp_ctrl    = (idx == 0) ? exp : shadow[0];
      exp_thresh  = (idx == 1) ? exp : shadow[1];
      exp_pattern = (idx == 2) ? exp : shadow[2];
      check_ctrl({name, " ctrl_q"}, exp_ctrl, ctrl_q);
      check_ctrl({name, " thresh_q"}, exp_thresh, thresh_q);
      check_pattern({name, " pattern_q"}, exp_pattern, pattern_q);
   endtask

   // ####################################################################
   // Bus driver
   // ####################################################################

   task automatic drive_beat(input logic b_cs, input logic b_adv, input logic b_rw,
                             input logic [eim_bus_pkg::ADDR_W-1:0] value);
      @(negedge clk);
      cs     = b_cs;
      adv    = b_adv;
      rw     = b_rw;
      bus_a  = value[18:16];
      bus_ad = value[15:0];
   endtask

   task automatic make_data(output logic [95:0] d);
      int k;
      for (k = 0; k < 6; k++) begin
         rng = lcg_next(rng);
         d[k*16 +: 16] = rng[31:16];
      end
   endtask

   // One burst with up to six data beats, then the checks on every output
   // With chain set, an outside address beat follows the data beats at once
   task automatic run_burst(input string name, input logic [eim_bus_pkg::ADDR_W-1:0] addr,
                            input logic is_read, input int nbeats, input logic [95:0] data,
                            input logic chain);
      int          idx;
      int          i;
      int          exp_words;
      int          exp_stb;
      int          stb0 [reg_map_pkg::NUM_REGS];
      int          oe0;
      int          cycles;
      logic [63:0] exp_payload;

      idx       = reg_index(addr);
      exp_words = (idx >= 0 && is_read) ? ((nbeats < 4) ? nbeats : 4) : 0;
      exp_stb   = (idx >= 0 && !is_read && nbeats > 0) ? 1 : 0;
      got_q.delete();
      oe0 = oe_cnt;
      for (i = 0; i < reg_map_pkg::NUM_REGS; i++)
         stb0[i] = stb_cnt[i];

      drive_beat(1'b1, 1'b1, is_read, addr);
      for (i = 0; i < nbeats; i++)
         drive_beat(1'b1, 1'b0, is_read, {3'b000, data[i*16 +: 16]});
      if (chain) begin
         // Next bus cycle without a gap, to an address outside the bank
         drive_beat(1'b1, 1'b1, 1'b0, BASE + 19'd3);
         for (i = 4; i < 6; i++)
            drive_beat(1'b1, 1'b0, 1'b0, {3'b000, ~data[i*16 +: 16]});
      end
      drive_beat(1'b0, 1'b0, 1'b0, '0);             // cs low ends the burst

      cycles = 0;
      while ((got_q.size() < exp_words || (exp_stb > 0 && stb_cnt[idx] == stb0[idx]))
             && cycles < TIMEOUT) begin
         @(negedge clk);
         cycles++;
      end
      if (cycles >= TIMEOUT) begin
         $display("%s: timed out waiting for readback words or the commit strobe", name);
         timeout_errs++;
      end
      repeat (4) @(negedge clk);                    // Catch late or extra pulses

      exp_payload = model_burst(idx, is_read, nbeats, data);
      check_payloads(name, idx, exp_payload);
      for (i = 0; i < exp_words && i < got_q.size(); i++)
         check_word($sformatf("%s word%0d", name, i), model_word(idx, i), got_q[i]);
      verify_oe_cycles(name, exp_words, oe_cnt - oe0);
      for (i = 0; i < reg_map_pkg::NUM_REGS; i++)
         check_strobe($sformatf("%s strobe%0d", name, i), (i == idx) ? exp_stb : 0,
                      stb_cnt[i] - stb0[i]);
   endtask

   function automatic logic [eim_bus_pkg::ADDR_W-1:0] reg_addr(input int r);
      case (r)
         0:       return BASE + reg_map_pkg::OFF_CTRL;
         1:       return BASE + reg_map_pkg::OFF_THRESH;
         2:       return BASE + reg_map_pkg::OFF_PATTERN;
         default: return BASE + 19'd3 + r[2:0];   // Just above the bank
      endcase
   endfunction

   // ####################################################################
   // Test sequence
   // ####################################################################

   initial begin
      logic [95:0] data;
      int          r;
      int          n;
      int          nbeats;
      logic        is_read;
      logic        chain;

      clk = 1'b0;
      reset = 1'b1;
      bus_ad = '0;
      bus_a = '0;
      adv = 1'b0;
      rw = 1'b0;
      cs = 1'b0;
      rng = 32'h51d3;
      oe_cnt = 0;
      value_errs = 0;
      timeout_errs = 0;
      for (r = 0; r < reg_map_pkg::NUM_REGS; r++) begin
         shadow[r] = 'x;                            // Register contents have no reset
         stb_cnt[r] = 0;
      end

      repeat (16) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
      @(negedge clk);
      if ({rbk.oe, ctrl_stb, thresh_stb, pattern_stb} !== 4'b0000) begin
         $display("Strobes or readback enable not low after reset");
         value_errs++;
      end

      for (r = 0; r < 3; r++) begin
         make_data(data);
         run_burst($sformatf("full_write_r%0d", r), reg_addr(r), 1'b0, 4, data, 1'b0);
      end
      for (r = 0; r < 3; r++)
         run_burst($sformatf("full_read_r%0d", r), reg_addr(r), 1'b1, 4, data, 1'b0);

      // Partial writes, then bursts longer than four beats
      for (r = 0; r < 3; r++) begin
         for (n = 1; n <= 3; n++) begin
            make_data(data);
            run_burst($sformatf("part_write_r%0d_n%0d", r, n), reg_addr(r), 1'b0, n,
                      data, 1'b0);
            run_burst($sformatf("part_read_r%0d_n%0d", r, n), reg_addr(r), 1'b1, 4,
                      data, 1'b0);
         end
         make_data(data);
         run_burst($sformatf("long_write_r%0d", r), reg_addr(r), 1'b0, 6, data, 1'b0);
         run_burst($sformatf("long_read_r%0d", r), reg_addr(r), 1'b1, 6, data, 1'b0);
      end

      make_data(data);
      run_burst("outside_above", BASE + 19'd3, 1'b0, 4, data, 1'b0);
      run_burst("outside_below", BASE - 19'd1, 1'b0, 4, data, 1'b0);
      run_burst("outside_upper", BASE ^ 19'h1_0000, 1'b0, 4, data, 1'b0);
      run_burst("outside_read", BASE ^ 19'h1_0000, 1'b1, 4, data, 1'b0);

      // Bursts cut short by the next address beat instead of cs low
      make_data(data);
      run_burst("chain_write", reg_addr(1), 1'b0, 2, data, 1'b1);
      run_burst("chain_read", reg_addr(1), 1'b1, 2, data, 1'b1);

      for (n = 0; n < NUM_RAND; n++) begin
         rng = lcg_next(rng);
         r       = int'(rng[31:30]);                // 3 selects an address outside
         is_read = rng[29];
         nbeats  = int'(rng[28:26]) % 7;
         chain   = rng[25];
         make_data(data);
         run_burst($sformatf("random%0d", n), reg_addr(r), is_read, nbeats, data, chain);
      end

      $display("Errors: %0d value mismatches, %0d timeouts", value_errs, timeout_errs);
      if (value_errs == 0 && timeout_errs == 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

endmodule

// ==== sources.f ====
eim_bus_pkg.sv
reg_map_pkg.sv
bus_capture.sv
burst_reg.sv
readback_mux.sv
eim_reg_bank.sv
tb_eim_reg_bank.sv
